// File: verilog/osd_pkg.sv
// ======================================================================
// Overlay geometry, datapath widths and serial command codes
// ======================================================================

package osd_pkg;

	// Overlay window size in pixels and lines.
	localparam int osd_width = 256;
	localparam int osd_height = 128;

	// Pixel and line counters cover sync periods up to 1023.
	localparam int cnt_w = 10;

	// One analog color channel.
	localparam int color_w = 6;

	// 2048-byte bitmap, eight blocks of 256 bytes.
	localparam int buf_addr_w = 11;

	// Command byte 0010_0bbb selects block bbb for writing.
	localparam logic [4:0] cmd_write = 5'b00100;

	// Command byte 0100_xxxe sets the overlay enable to e.
	localparam logic [3:0] cmd_enable = 4'b0100;

endpackage

// File: verilog/osd_spi_rx.sv
`timescale 1ns/1ps

module osd_spi_rx (
	input  logic                          pclk,
	input  logic                          ss,
	input  logic                          spi_sel,
	input  logic                          sck,
	input  logic                          sdi,
	output logic                          wr_en,
	output logic [osd_pkg::buf_addr_w-1:0] wr_addr,
	output logic [7:0]                    wr_data,
	output logic                          osd_enable
);

	logic [2:0] sck_sync;
	logic [1:0] sdi_sync;
	logic [1:0] sel_sync;
	logic [6:0] shift_reg;
	logic [2:0] bit_cnt;
	logic       cmd_phase;
	logic       write_mode;
	logic [osd_pkg::buf_addr_w-1:0] addr_ptr;
	logic       sck_rise;
	logic       sel_active;
	logic       byte_done;
	logic       write_byte;
	logic [7:0] rx_byte;

	// The extra sck stage gives the edge detector its previous value.
	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sel_active = sel_sync[1];
	assign byte_done = sel_active && sck_rise && (bit_cnt == 3'd7);
	assign write_byte = byte_done && !cmd_phase && write_mode;
	assign rx_byte = {shift_reg, sdi_sync[1]};

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			sck_sync <= '0;
			sdi_sync <= '0;
			sel_sync <= '0;
			bit_cnt <= '0;
			cmd_phase <= 1'b1;
			write_mode <= 1'b0;
			addr_ptr <= '0;
			wr_en <= 1'b0;
			osd_enable <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			sdi_sync <= {sdi_sync[0], sdi};
			sel_sync <= {sel_sync[0], spi_sel};
			wr_en <= write_byte;

			if (!sel_active) begin
				// Every transfer starts over with a command byte.
				bit_cnt <= '0;
				cmd_phase <= 1'b1;
				write_mode <= 1'b0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (byte_done && cmd_phase) begin
					cmd_phase <= 1'b0;
					if (rx_byte[7:3] == osd_pkg::cmd_write) begin
						write_mode <= 1'b1;
						addr_ptr <= {rx_byte[2:0], 8'h00};
					end
					if (rx_byte[7:4] == osd_pkg::cmd_enable)
						osd_enable <= rx_byte[0];
				end
			end

			if (write_byte)
				addr_ptr <= addr_ptr + 1'b1;
		end
	end

	always_ff @(posedge pclk) begin
		if (sel_active && sck_rise)
			shift_reg <= rx_byte[6:0];
		if (write_byte) begin
			wr_addr <= addr_ptr;
			wr_data <= rx_byte;
		end
	end

	// The select input is still high when a byte is committed to the bitmap.
	a_wr_in_transfer: assert property (@(posedge pclk) disable iff (ss)
		wr_en |-> spi_sel);

endmodule

// File: verilog/osd_timing.sv
`timescale 1ns/1ps

module osd_timing #(
	parameter logic [osd_pkg::cnt_w-1:0] osd_x_offset = '0,
	parameter logic [osd_pkg::cnt_w-1:0] osd_y_offset = '0
) (
	input  logic                       pclk,
	input  logic                       ss,
	input  logic [osd_pkg::color_w-1:0] red_in,
	input  logic [osd_pkg::color_w-1:0] green_in,
	input  logic [osd_pkg::color_w-1:0] blue_in,
	input  logic                       hs_in,
	input  logic                       vs_in,
	output logic [osd_pkg::color_w-1:0] red,
	output logic [osd_pkg::color_w-1:0] green,
	output logic [osd_pkg::color_w-1:0] blue,
	output logic                       hs,
	output logic                       vs,
	output logic                       win_active,
	output logic [7:0]                 win_col,
	output logic [6:0]                 win_row,
	output logic                       scanline
);

	localparam int cw = osd_pkg::cnt_w;

	logic          primed;
	logic [cw-1:0] h_cnt, v_cnt, h_next, v_next;
	logic [cw-1:0] hs_high, hs_low, vs_high, vs_low;
	logic [1:0]    h_meas, v_meas;
	logic          hs_rise, hs_fall, vs_edge;
	logic          h_idle, v_idle;
	logic [cw-1:0] h_ctr, v_ctr, h_start, v_start, h_rel, v_rel;
	logic          h_in, v_in;

	// ==================================================================
	// Sync edges and next counter values for the pixel being registered
	// ==================================================================
	assign hs_rise = primed & hs_in & ~hs;
	assign hs_fall = primed & ~hs_in & hs;
	assign vs_edge = primed & (vs_in ^ vs);

	assign h_next = (hs_rise | hs_fall) ? '0 : h_cnt + 1'b1;
	assign v_next = vs_edge ? '0 : (hs_rise ? v_cnt + 1'b1 : v_cnt);

	// The longer phase is the display phase; its level is the idle level.
	assign h_idle = hs_high >= hs_low;
	assign v_idle = vs_high >= vs_low;
	assign h_ctr = (h_idle ? hs_high : hs_low) >> 1;
	assign v_ctr = (v_idle ? vs_high : vs_low) >> 1;

	assign h_start = h_ctr + osd_x_offset - cw'(osd_pkg::osd_width / 2);
	assign v_start = v_ctr + osd_y_offset - cw'(osd_pkg::osd_height / 2);
	assign h_rel = h_next - h_start;
	assign v_rel = v_next - v_start;

	assign h_in = (h_meas == 2'd3) && (hs_in == h_idle) && (h_rel < cw'(osd_pkg::osd_width));
	assign v_in = (v_meas == 2'd3) && (vs_in == v_idle) && (v_rel < cw'(osd_pkg::osd_height));

	// ==================================================================
	// Stage 1 registers
	// ==================================================================
	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			primed <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
			hs <= 1'b0;
			vs <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
			hs_high <= '0;
			hs_low <= '0;
			vs_high <= '0;
			vs_low <= '0;
			h_meas <= '0;
			v_meas <= '0;
			win_active <= 1'b0;
			win_col <= '0;
			win_row <= '0;
			scanline <= 1'b0;
		end else begin
			primed <= 1'b1;
			red <= red_in;
			green <= green_in;
			blue <= blue_in;
			hs <= hs_in;
			vs <= vs_in;
			h_cnt <= h_next;
			v_cnt <= v_next;

			// A phase length is only trusted once it started at a real edge.
			if (hs_fall)
				hs_high <= h_cnt + 1'b1;
			if (hs_rise)
				hs_low <= h_cnt + 1'b1;
			if ((hs_rise | hs_fall) && h_meas != 2'd3)
				h_meas <= h_meas + 2'd1;

			// The line count at a vsync edge is the number of lines in the phase.
			if (vs_edge) begin
				if (vs_in)
					vs_low <= v_cnt;
				else
					vs_high <= v_cnt;
				if (v_meas != 2'd3)
					v_meas <= v_meas + 2'd1;
			end

			if (hs_fall)
				scanline <= ~scanline;

			win_active <= h_in & v_in;
			win_col <= h_rel[7:0];
			win_row <= v_rel[6:0];
		end
	end

	// Within one active run the column advances by one and never wraps past the width.
	a_col_in_window: assert property (@(posedge pclk) disable iff (ss)
		win_active && $past(win_active) |-> {1'b0, win_col} == {1'b0, $past(win_col)} + 9'd1);

endmodule

// File: verilog/osd_fetch.sv
`timescale 1ns/1ps

module osd_fetch (
	input  logic                           pclk,
	input  logic                           ss,
	input  logic                           wr_en,
	input  logic [osd_pkg::buf_addr_w-1:0] wr_addr,
	input  logic [7:0]                     wr_data,
	input  logic [osd_pkg::color_w-1:0]    red,
	input  logic [osd_pkg::color_w-1:0]    green,
	input  logic [osd_pkg::color_w-1:0]    blue,
	input  logic                           hs,
	input  logic                           vs,
	input  logic                           win_active,
	input  logic [7:0]                     win_col,
	input  logic [6:0]                     win_row,
	input  logic                           scanline,
	output logic [osd_pkg::color_w-1:0]    red_q,
	output logic [osd_pkg::color_w-1:0]    green_q,
	output logic [osd_pkg::color_w-1:0]    blue_q,
	output logic                           hs_q,
	output logic                           vs_q,
	output logic                           win_active_q,
	output logic                           scanline_q,
	output logic                           osd_pixel
);

	logic [7:0] bitmap [0:(2**osd_pkg::buf_addr_w)-1];
	logic [7:0] rd_byte;
	logic [2:0] bit_sel;

	// Each byte covers eight pixels in a column, two lines per bit.
	always_ff @(posedge pclk) begin
		if (wr_en)
			bitmap[wr_addr] <= wr_data;
		rd_byte <= bitmap[{win_row[6:4], win_col}];
		bit_sel <= win_row[3:1];
	end

	assign osd_pixel = rd_byte[bit_sel];

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			red_q <= '0;
			green_q <= '0;
			blue_q <= '0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			win_active_q <= 1'b0;
			scanline_q <= 1'b0;
		end else begin
			red_q <= red;
			green_q <= green;
			blue_q <= blue;
			hs_q <= hs;
			vs_q <= vs;
			win_active_q <= win_active;
			scanline_q <= scanline;
		end
	end

endmodule

// File: verilog/osd_mix.sv
`timescale 1ns/1ps

module osd_mix #(
	parameter logic [2:0] osd_color = 3'd1
) (
	input  logic                        pclk,
	input  logic                        ss,
	input  logic [osd_pkg::color_w-1:0] red,
	input  logic [osd_pkg::color_w-1:0] green,
	input  logic [osd_pkg::color_w-1:0] blue,
	input  logic                        hs,
	input  logic                        vs,
	input  logic                        win_active,
	input  logic                        osd_pixel,
	input  logic                        scanline,
	input  logic                        scanline_ena,
	input  logic                        osd_enable,
	output logic [osd_pkg::color_w-1:0] red_out,
	output logic [osd_pkg::color_w-1:0] green_out,
	output logic [osd_pkg::color_w-1:0] blue_out,
	output logic                        hs_out,
	output logic                        vs_out
);

	localparam int cw = osd_pkg::color_w;

	logic dim;
	logic overlay;

	// Overlay keeps the top three bits of the video so it looks translucent.
	function automatic logic [cw-1:0] mix_chan(input logic [cw-1:0] chan, input logic dim_on,
		input logic ovl_on, input logic pix, input logic key);
		logic [cw-1:0] base;
		base = dim_on ? {1'b0, chan[cw-1:1]} : chan;
		return ovl_on ? {pix, pix, key, base[cw-1 -: 3]} : base;
	endfunction

	assign dim = scanline & scanline_ena;
	assign overlay = win_active & osd_enable;

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			red_out <= '0;
			green_out <= '0;
			blue_out <= '0;
			hs_out <= 1'b0;
			vs_out <= 1'b0;
		end else begin
			red_out <= mix_chan(red, dim, overlay, osd_pixel, osd_color[2]);
			green_out <= mix_chan(green, dim, overlay, osd_pixel, osd_color[1]);
			blue_out <= mix_chan(blue, dim, overlay, osd_pixel, osd_color[0]);
			hs_out <= hs;
			vs_out <= vs;
		end
	end

endmodule

// File: verilog/osd_overlay.sv
`timescale 1ns/1ps

module osd_overlay #(
	parameter logic [osd_pkg::cnt_w-1:0] osd_x_offset = '0,
	parameter logic [osd_pkg::cnt_w-1:0] osd_y_offset = '0,
	parameter logic [2:0]                osd_color = 3'd1
) (
	input  logic                        pclk,
	input  logic                        ss,
	input  logic                        spi_sel,
	input  logic                        sck,
	input  logic                        sdi,
	input  logic [osd_pkg::color_w-1:0] red_in,
	input  logic [osd_pkg::color_w-1:0] green_in,
	input  logic [osd_pkg::color_w-1:0] blue_in,
	input  logic                        hs_in,
	input  logic                        vs_in,
	input  logic                        scanline_ena,
	output logic [osd_pkg::color_w-1:0] red_out,
	output logic [osd_pkg::color_w-1:0] green_out,
	output logic [osd_pkg::color_w-1:0] blue_out,
	output logic                        hs_out,
	output logic                        vs_out
);

	logic                           wr_en;
	logic [osd_pkg::buf_addr_w-1:0] wr_addr;
	logic [7:0]                     wr_data;
	logic                           osd_enable;

	// Stage 1 outputs.
	logic [osd_pkg::color_w-1:0] red_s1, green_s1, blue_s1;
	logic                        hs_s1, vs_s1, win_active_s1, scanline_s1;
	logic [7:0]                  win_col;
	logic [6:0]                  win_row;

	// Stage 2 outputs.
	logic [osd_pkg::color_w-1:0] red_s2, green_s2, blue_s2;
	logic                        hs_s2, vs_s2, win_active_s2, scanline_s2;
	logic                        osd_pixel;

	osd_spi_rx u_spi_rx (
		.pclk(pclk), .ss(ss), .spi_sel(spi_sel), .sck(sck), .sdi(sdi),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .osd_enable(osd_enable)
	);

	osd_timing #(.osd_x_offset(osd_x_offset), .osd_y_offset(osd_y_offset)) u_timing (
		.pclk(pclk), .ss(ss),
		.red_in(red_in), .green_in(green_in), .blue_in(blue_in), .hs_in(hs_in), .vs_in(vs_in),
		.red(red_s1), .green(green_s1), .blue(blue_s1), .hs(hs_s1), .vs(vs_s1),
		.win_active(win_active_s1), .win_col(win_col), .win_row(win_row),
		.scanline(scanline_s1)
	);

	osd_fetch u_fetch (
		.pclk(pclk), .ss(ss), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.red(red_s1), .green(green_s1), .blue(blue_s1), .hs(hs_s1), .vs(vs_s1),
		.win_active(win_active_s1), .win_col(win_col), .win_row(win_row),
		.scanline(scanline_s1),
		.red_q(red_s2), .green_q(green_s2), .blue_q(blue_s2), .hs_q(hs_s2), .vs_q(vs_s2),
		.win_active_q(win_active_s2), .scanline_q(scanline_s2), .osd_pixel(osd_pixel)
	);

	osd_mix #(.osd_color(osd_color)) u_mix (
		.pclk(pclk), .ss(ss),
		.red(red_s2), .green(green_s2), .blue(blue_s2), .hs(hs_s2), .vs(vs_s2),
		.win_active(win_active_s2), .osd_pixel(osd_pixel), .scanline(scanline_s2),
		.scanline_ena(scanline_ena), .osd_enable(osd_enable),
		.red_out(red_out), .green_out(green_out), .blue_out(blue_out),
		.hs_out(hs_out), .vs_out(vs_out)
	);

endmodule

// File: dv/osd_overlay_tb.sv
`timescale 1ns/1ps

module osd_overlay_tb;

	localparam int cw = osd_pkg::color_w;
	localparam int h_total = 500;
	localparam int v_total = 320;
	localparam int h_sync = 40;
	localparam int v_sync = 4;
	localparam int max_records = 64;
	localparam int probe_limit = 2 * h_total * v_total + 1000;

	logic          pclk;
	logic          ss;
	logic          spi_sel;
	logic          sck;
	logic          sdi;
	logic [cw-1:0] red_in, green_in, blue_in;
	logic          hs_in, vs_in;
	logic          scanline_ena;
	logic [cw-1:0] red_out, green_out, blue_out;
	logic          hs_out, vs_out;

	logic [55:0] tests [0:max_records-1];
	logic [31:0] lfsr;
	logic        video_run;
	int          cur_line, cur_col;
	int          last_line, last_col;
	logic        scan_model, last_scan;
	logic [2:0]  hs_hist, vs_hist;
	int          driven;

	osd_overlay DUT (
		.pclk(pclk), .ss(ss), .spi_sel(spi_sel), .sck(sck), .sdi(sdi),
		.red_in(red_in), .green_in(green_in), .blue_in(blue_in),
		.hs_in(hs_in), .vs_in(vs_in), .scanline_ena(scanline_ena),
		.red_out(red_out), .green_out(green_out), .blue_out(blue_out),
		.hs_out(hs_out), .vs_out(vs_out)
	);

	always #10 pclk = ~pclk;

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// ==================================================================
	// Video source
	// ==================================================================

	// Taps 32, 22, 2 and 1.
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_channel(output logic [cw-1:0] v);
		for (int i = 0; i < cw; i++) begin
			lfsr = next_lfsr(lfsr);
			v = {v[cw-2:0], lfsr[0]};
		end
	endtask

	task automatic drive_pixel();
		logic          hs_new, vs_new;
		logic [cw-1:0] r, g, b;
		hs_new = (cur_col >= h_sync);
		vs_new = (cur_line >= v_sync);
		// The scanline flag flips on every falling hsync edge.
		if (hs_in && !hs_new)
			scan_model = ~scan_model;
		last_line = cur_line;
		last_col = cur_col;
		last_scan = scan_model;
		random_channel(r);
		random_channel(g);
		random_channel(b);
		red_in = r;
		green_in = g;
		blue_in = b;
		hs_in = hs_new;
		vs_in = vs_new;
		hs_hist = {hs_hist[1:0], hs_new};
		vs_hist = {vs_hist[1:0], vs_new};
		driven++;
		cur_col++;
		if (cur_col == h_total) begin
			cur_col = 0;
			cur_line = (cur_line == v_total - 1) ? 0 : cur_line + 1;
		end
	endtask

	// Sync must leave the DUT exactly three pixels after it entered.
	always @(negedge pclk) begin
		if (video_run) begin
			if (driven >= 3) begin
				assert (hs_out == hs_hist[2] && vs_out == vs_hist[2])
				else stop_with_error($sformatf("error at time %0t: sync out %b%b, expected %b%b",
					$time, hs_out, vs_out, hs_hist[2], vs_hist[2]));
			end
			drive_pixel();
		end
	end

	// ==================================================================
	// Serial link and probes
	// ==================================================================
	task automatic send_byte(input logic [7:0] value);
		for (int i = 7; i >= 0; i--) begin
			@(negedge pclk);
			sck = 1'b0;
			sdi = value[i];
			repeat (2) @(negedge pclk);
			sck = 1'b1;
			@(negedge pclk);
		end
	endtask

	task automatic serial_transfer(input logic [55:0] rec);
		int count;
		count = int'(rec[47:36]);
		if (rec[48]) begin
			@(negedge pclk);
			sck = 1'b0;
			spi_sel = 1'b1;
			repeat (3) @(negedge pclk);
		end
		for (int n = 0; n < count; n++)
			send_byte(rec[7:0]);
		if (rec[49]) begin
			@(negedge pclk);
			sck = 1'b0;
			repeat (3) @(negedge pclk);
			spi_sel = 1'b0;
			repeat (4) @(negedge pclk);
		end
	endtask

	task automatic check_probe(input logic [55:0] rec);
		int            line, col, waited;
		logic          dim;
		logic [cw-1:0] base_r, base_g, base_b;
		logic [cw-1:0] exp_r, exp_g, exp_b;
		line = int'(rec[47:36]);
		col = int'(rec[35:24]);
		waited = 0;
		do begin
			@(posedge pclk);
			waited++;
		end while ((last_line != line || last_col != col) && waited < probe_limit);
		if (last_line != line || last_col != col)
			stop_with_error($sformatf("video never reached line %0d column %0d", line, col));
		dim = last_scan & scanline_ena;
		base_r = dim ? (red_in >> 1) : red_in;
		base_g = dim ? (green_in >> 1) : green_in;
		base_b = dim ? (blue_in >> 1) : blue_in;
		// Overlay probes carry the pixel and key bits; the rest is dimmed video.
		if (rec[51:48] == 4'h1) begin
			exp_r = {rec[18:16], base_r[cw-1:cw-3]};
			exp_g = {rec[10:8], base_g[cw-1:cw-3]};
			exp_b = {rec[2:0], base_b[cw-1:cw-3]};
		end else begin
			exp_r = base_r;
			exp_g = base_g;
			exp_b = base_b;
		end
		repeat (2) @(posedge pclk);
		@(negedge pclk);
		assert (red_out == exp_r && green_out == exp_g && blue_out == exp_b)
		else stop_with_error($sformatf(
			"error at time %0t: line %0d column %0d gave %h %h %h, expected %h %h %h",
			$time, line, col, red_out, green_out, blue_out, exp_r, exp_g, exp_b));
	endtask

	initial begin
		int         idx;
		int         probes;
		logic [3:0] kind;
		pclk = 1'b0;
		ss = 1'b1;
		spi_sel = 1'b0;
		sck = 1'b0;
		sdi = 1'b0;
		red_in = '0;
		green_in = '0;
		blue_in = '0;
		hs_in = 1'b1;
		vs_in = 1'b1;
		scanline_ena = 1'b0;
		lfsr = 32'h444b290a;
		video_run = 1'b0;
		cur_line = 0;
		cur_col = 0;
		last_line = -1;
		last_col = -1;
		scan_model = 1'b0;
		last_scan = 1'b0;
		hs_hist = '1;
		vs_hist = '1;
		driven = 0;
		probes = 0;
		for (idx = 0; idx < max_records; idx++)
			tests[idx] = '0;
		$readmemh("dv/osd_tests.txt", tests);

		repeat (2) @(posedge pclk);
		@(negedge pclk);
		ss = 1'b0;
		repeat (4) @(negedge pclk);
		@(posedge pclk);
		video_run = 1'b1;

		for (idx = 0; idx < max_records; idx++) begin
			kind = tests[idx][55:52];
			if (kind == 4'h1) begin
				serial_transfer(tests[idx]);
			end else if (kind == 4'h2) begin
				@(negedge pclk);
				scanline_ena = tests[idx][48];
			end else if (kind == 4'h3) begin
				check_probe(tests[idx]);
				probes++;
			end
		end

		if (probes > 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			stop_with_error("the tests file held no probe records");
		end
	end

endmodule

// File: dv/osd_tests.txt
// kind_mode_line_column_red_green_blue in hex. Kind 1 is a serial byte (mode bit 0 selects, bit 1 releases, line is the repeat count, blue the byte).
// Kind 2 sets scanline_ena to mode. Kind 3 is a probe; mode 0 expects video, mode 1 gives the top three overlay bits per channel.
3_0_00a_03c_00_00_00
3_0_078_12c_00_00_00
2_1_000_000_00_00_00
3_0_082_0fa_00_00_00
3_0_083_0fa_00_00_00
2_0_000_000_00_00_00
1_1_001_000_00_00_20
1_0_001_000_00_00_0f
1_2_001_000_00_00_f0
1_1_001_000_00_00_23
1_0_001_000_00_00_a5
1_0_0fe_000_00_00_00
1_2_001_000_00_00_5a
1_3_001_000_00_00_41
3_0_061_08d_00_00_00
3_1_062_08e_06_06_07
3_1_063_08f_00_00_01
3_1_091_08e_06_06_07
3_1_093_08e_00_00_01
3_1_093_18d_06_06_07
3_0_094_18e_00_00_00
3_1_0a0_08e_06_06_07
1_3_001_000_00_00_40
3_0_096_0c8_00_00_00

// File: osd_overlay.f
verilog/osd_pkg.sv
verilog/osd_spi_rx.sv
verilog/osd_timing.sv
verilog/osd_fetch.sv
verilog/osd_mix.sv
verilog/osd_overlay.sv
dv/osd_overlay_tb.sv

// File: Makefile
# Verilator build and run for the OSD overlay testbench.

VERILATOR ?= verilator
TOP       ?= osd_overlay_tb
FILELIST  ?= osd_overlay.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
